// ==== hdl/cuckoo_config.svh ====
`ifndef CUCKOO_CONFIG_SVH
`define CUCKOO_CONFIG_SVH

// ----------------------------------------
// Table geometry
// ----------------------------------------
`define CUCKOO_KEY_W      16
`define CUCKOO_VALUE_W    16
`define CUCKOO_NUM_TABLES 2
// Slots per bank are 2**CUCKOO_BANK_AW
`define CUCKOO_BANK_AW    4

// ----------------------------------------
// Insert behaviour and statistics
// ----------------------------------------
`define CUCKOO_OPS_LIMIT  4
`define CUCKOO_CNT_W      16

`endif

// ==== hdl/cuckoo_pkg.sv ====
`include "cuckoo_config.svh"

package cuckoo_pkg;

    // ----------------------------------------
    // Derived sizes
    // ----------------------------------------
    localparam int NUM_TABLES  = `CUCKOO_NUM_TABLES;
    localparam int BANK_SLOTS  = 1 << `CUCKOO_BANK_AW;
    localparam int TOTAL_SLOTS = NUM_TABLES * BANK_SLOTS;
    localparam int BANK_IDX_W  = (NUM_TABLES > 1) ? $clog2(NUM_TABLES) : 1;
    localparam int FILL_W      = $clog2(TOTAL_SLOTS + 1);

    // ----------------------------------------
    // Data types
    // ----------------------------------------
    typedef logic [`CUCKOO_KEY_W-1:0]   key_t;
    typedef logic [`CUCKOO_VALUE_W-1:0] value_t;

    // Key travels with the value so a displaced entry can rehash
    typedef struct packed {
        key_t   key;
        value_t value;
    } entry_t;

    typedef logic [BANK_IDX_W-1:0]      bank_idx_t;
    typedef logic [`CUCKOO_BANK_AW-1:0] slot_t;
    typedef logic [`CUCKOO_CNT_W-1:0]   cnt_t;
    typedef logic [FILL_W-1:0]          fill_t;

    typedef enum logic [2:0] {
        COMMAND_NOP     = 3'd0,
        COMMAND_CLEAR   = 3'd1,
        COMMAND_GET     = 3'd2,
        COMMAND_SET     = 3'd3,
        COMMAND_UNSET   = 3'd4,
        COMMAND_REPLACE = 3'd5
    } command_t;

    typedef enum logic {
        STATUS_OK    = 1'b0,
        STATUS_ERROR = 1'b1
    } status_t;

endpackage : cuckoo_pkg

// ==== hdl/cuckoo_bank_if.sv ====
interface cuckoo_bank_if;
    import cuckoo_pkg::*;

    // Request side, driven by the controller
    logic      req;
    command_t  command;
    bank_idx_t bank_sel;
    key_t      key;
    entry_t    set_entry;

    // Response side, one cycle after req
    logic      ack;
    status_t   status;
    logic      get_valid;
    entry_t    get_entry;

    modport controller (
        output req, command, bank_sel, key, set_entry,
        input  ack, status, get_valid, get_entry
    );

    modport bank (
        input  req, command, bank_sel, key, set_entry,
        output ack, status, get_valid, get_entry
    );

endinterface : cuckoo_bank_if

// ==== hdl/cuckoo_controller.sv ====
`include "cuckoo_config.svh"

module cuckoo_controller (
    input  logic                 clk,
    input  logic                 __srst,
    input  logic                 req,
    input  cuckoo_pkg::command_t command,
    input  cuckoo_pkg::key_t     key,
    input  cuckoo_pkg::value_t   set_value,
    output logic                 rdy,
    output logic                 ack,
    output cuckoo_pkg::status_t  status,
    output logic                 get_valid,
    output cuckoo_pkg::key_t     get_key,
    output cuckoo_pkg::value_t   get_value,
    output cuckoo_pkg::command_t done_command,
    output cuckoo_pkg::status_t  done_status,
    cuckoo_bank_if.controller    bank
);
    import cuckoo_pkg::*;

    typedef enum logic [3:0] {
        ST_RESET,
        ST_IDLE,
        ST_CLEAR_REQ,
        ST_CLEAR_WAIT,
        ST_PROBE_REQ,
        ST_PROBE_WAIT,
        ST_DELETE_REQ,
        ST_DELETE_WAIT,
        ST_READ_REQ,
        ST_READ_WAIT,
        ST_WRITE_REQ,
        ST_WRITE_WAIT,
        ST_DONE,
        ST_FAIL
    } state_t;

    state_t    state;
    state_t    nxt_state;
    logic      accept;
    command_t  cur_command;
    entry_t    cur_entry;
    key_t      orig_key;
    entry_t    stash;
    logic      stash_valid;
    logic      loop_hit;
    logic      hit;
    entry_t    hit_entry;
    bank_idx_t bank_idx;
    bank_idx_t bank_next;
    logic      bank_last;
    logic      key_match;
    cnt_t      ops;

    assign accept    = req && rdy;
    assign bank_last = (bank_idx == bank_idx_t'(NUM_TABLES - 1));
    assign bank_next = bank_last ? '0 : bank_idx_t'(bank_idx + 1'b1);
    assign key_match = bank.get_valid && (bank.get_entry.key == cur_entry.key);

    // ----------------------------------------
    // Command FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) state <= ST_RESET;
        else        state <= nxt_state;
    end

    always_comb begin
        nxt_state = state;
        case (state)
            ST_RESET: nxt_state = ST_IDLE;
            ST_IDLE: begin
                if (req) begin
                    case (command)
                        COMMAND_NOP:     nxt_state = ST_DONE;
                        COMMAND_CLEAR:   nxt_state = ST_CLEAR_REQ;
                        COMMAND_GET,
                        COMMAND_SET,
                        COMMAND_UNSET,
                        COMMAND_REPLACE: nxt_state = ST_PROBE_REQ;
                        default:         nxt_state = ST_FAIL;
                    endcase
                end
            end
            ST_CLEAR_REQ: nxt_state = ST_CLEAR_WAIT;
            ST_CLEAR_WAIT: begin
                if (bank.ack) begin
                    if (bank.status != STATUS_OK) nxt_state = ST_FAIL;
                    else if (bank_last)           nxt_state = ST_DONE;
                    else                          nxt_state = ST_CLEAR_REQ;
                end
            end
            ST_PROBE_REQ: nxt_state = ST_PROBE_WAIT;
            ST_PROBE_WAIT: begin
                if (bank.ack) begin
                    if (bank.status != STATUS_OK) begin
                        nxt_state = ST_FAIL;
                    end else if (key_match) begin
                        // Key present in this bank
                        case (cur_command)
                            COMMAND_GET:     nxt_state = ST_DONE;
                            COMMAND_UNSET:   nxt_state = ST_DELETE_REQ;
                            COMMAND_REPLACE: nxt_state = ST_WRITE_REQ;
                            default:         nxt_state = ST_FAIL;
                        endcase
                    end else if (!bank_last) begin
                        nxt_state = ST_PROBE_REQ;
                    end else if (cur_command == COMMAND_GET) begin
                        nxt_state = ST_DONE;
                    end else if (cur_command == COMMAND_SET) begin
                        nxt_state = ST_READ_REQ;
                    end else begin
                        nxt_state = ST_FAIL;
                    end
                end
            end
            ST_DELETE_REQ: nxt_state = ST_DELETE_WAIT;
            ST_DELETE_WAIT: begin
                if (bank.ack) begin
                    if (bank.status == STATUS_OK && key_match) nxt_state = ST_DONE;
                    else                                       nxt_state = ST_FAIL;
                end
            end
            ST_READ_REQ: nxt_state = ST_READ_WAIT;
            ST_READ_WAIT: begin
                if (bank.ack) begin
                    if (bank.status != STATUS_OK) nxt_state = ST_FAIL;
                    else                          nxt_state = ST_WRITE_REQ;
                end
            end
            ST_WRITE_REQ: nxt_state = ST_WRITE_WAIT;
            ST_WRITE_WAIT: begin
                if (bank.ack) begin
                    if (bank.status != STATUS_OK) nxt_state = ST_FAIL;
                    else if (loop_hit)            nxt_state = ST_FAIL;
                    else if (stash_valid)         nxt_state = ST_READ_REQ;
                    else                          nxt_state = ST_DONE;
                end
            end
            ST_DONE,
            ST_FAIL: nxt_state = ST_IDLE;
            default: nxt_state = ST_RESET;
        endcase
    end

    // ----------------------------------------
    // Request context and displacement
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_command     <= command;
            cur_entry.key   <= key;
            cur_entry.value <= set_value;
            orig_key        <= key;
        end else if (state == ST_WRITE_WAIT && bank.ack && stash_valid) begin
            // Evicted entry is now in hand for the next bank
            cur_entry <= stash;
        end
        if (state == ST_READ_WAIT && bank.ack) stash <= bank.get_entry;
        if (state == ST_PROBE_WAIT && bank.ack && key_match) hit_entry <= bank.get_entry;
    end

    always_ff @(posedge clk) begin
        if (__srst || accept) begin
            bank_idx    <= '0;
            ops         <= '0;
            stash_valid <= 1'b0;
            loop_hit    <= 1'b0;
            hit         <= 1'b0;
        end else if (bank.ack) begin
            case (state)
                ST_CLEAR_WAIT: bank_idx <= bank_next;
                ST_PROBE_WAIT: begin
                    // Wrap after the last bank so an insert starts at bank 0
                    if (!key_match) bank_idx <= bank_next;
                    if (key_match && cur_command == COMMAND_GET) hit <= 1'b1;
                end
                ST_READ_WAIT: begin
                    stash_valid <= bank.get_valid;
                    // Original key back in hand after too many moves
                    if (bank.get_valid && bank.get_entry.key == orig_key &&
                        ops > `CUCKOO_OPS_LIMIT) begin
                        loop_hit <= 1'b1;
                    end
                end
                ST_WRITE_WAIT: begin
                    stash_valid <= 1'b0;
                    if (stash_valid) begin
                        bank_idx <= bank_next;
                        ops      <= ops + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Bank and requester ports
    // ----------------------------------------
    assign bank.req = state inside {ST_CLEAR_REQ, ST_PROBE_REQ, ST_DELETE_REQ,
                                    ST_READ_REQ, ST_WRITE_REQ};

    always_comb begin
        case (state)
            ST_CLEAR_REQ:              bank.command = COMMAND_CLEAR;
            ST_PROBE_REQ, ST_READ_REQ: bank.command = COMMAND_GET;
            ST_DELETE_REQ:             bank.command = COMMAND_UNSET;
            ST_WRITE_REQ:              bank.command = COMMAND_SET;
            default:                   bank.command = COMMAND_NOP;
        endcase
    end

    assign bank.bank_sel  = bank_idx;
    assign bank.key       = cur_entry.key;
    assign bank.set_entry = cur_entry;

    assign rdy          = (state == ST_IDLE);
    assign ack          = (state == ST_DONE) || (state == ST_FAIL);
    assign status       = (state == ST_DONE) ? STATUS_OK : STATUS_ERROR;
    assign get_valid    = ack && hit;
    assign get_key      = get_valid ? hit_entry.key : '0;
    assign get_value    = get_valid ? hit_entry.value : '0;
    assign done_command = cur_command;
    assign done_status  = status;

    a_ack_pulse: assert property (@(posedge clk) disable iff (__srst) ack |=> !ack)
        else $error("ack held for more than one cycle");
    a_rdy_ack: assert property (@(posedge clk) disable iff (__srst) !(rdy && ack))
        else $error("rdy and ack high together");

endmodule : cuckoo_controller

// ==== hdl/cuckoo_bank_array.sv ====
`include "cuckoo_config.svh"

module cuckoo_bank_array (
    input  logic        clk,
    input  logic        __srst,
    cuckoo_bank_if.bank bank
);
    import cuckoo_pkg::*;

    logic [BANK_SLOTS-1:0] valid [NUM_TABLES];
    entry_t                mem   [NUM_TABLES][BANK_SLOTS];
    slot_t                 slot;
    logic                  cmd_ok;

    // ----------------------------------------
    // Hashing
    // ----------------------------------------
    // Bank b uses its own key slice, so all slices must fit in the key
    always_comb begin
        slot = '0;
        for (int b = 0; b < NUM_TABLES; b++) begin
            if (bank.bank_sel == bank_idx_t'(b)) begin
                slot = bank.key[b*`CUCKOO_BANK_AW +: `CUCKOO_BANK_AW];
            end
        end
    end

    assign cmd_ok = bank.command inside {COMMAND_CLEAR, COMMAND_GET, COMMAND_SET,
                                         COMMAND_UNSET};

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            for (int b = 0; b < NUM_TABLES; b++) begin
                valid[b] <= '0;
            end
        end else if (bank.req) begin
            case (bank.command)
                COMMAND_SET:   valid[bank.bank_sel][slot] <= 1'b1;
                COMMAND_UNSET: valid[bank.bank_sel][slot] <= 1'b0;
                // Only the addressed bank is wiped
                COMMAND_CLEAR: valid[bank.bank_sel] <= '0;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bank.req && bank.command == COMMAND_SET) begin
            mem[bank.bank_sel][slot] <= bank.set_entry;
        end
    end

    // ----------------------------------------
    // Response
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) bank.ack <= 1'b0;
        else        bank.ack <= bank.req;
    end

    // Old contents returned, so UNSET reports what it removed
    always_ff @(posedge clk) begin
        if (bank.req) begin
            bank.status    <= cmd_ok ? STATUS_OK : STATUS_ERROR;
            bank.get_valid <= valid[bank.bank_sel][slot];
            bank.get_entry <= mem[bank.bank_sel][slot];
        end
    end

    a_req_ack: assert property (@(posedge clk) disable iff (__srst)
        bank.req |=> bank.ack && !bank.req)
        else $error("bank ack missing or new request during ack");

endmodule : cuckoo_bank_array

// ==== hdl/cuckoo_stats.sv ====
module cuckoo_stats (
    input  logic                 clk,
    input  logic                 __srst,
    input  logic                 done,
    input  cuckoo_pkg::command_t done_command,
    input  cuckoo_pkg::status_t  done_status,
    output cuckoo_pkg::fill_t    fill,
    output logic                 empty,
    output cuckoo_pkg::cnt_t     insert_fail_cnt,
    output cuckoo_pkg::cnt_t     delete_fail_cnt
);
    import cuckoo_pkg::*;

    logic done_ok;

    assign done_ok = (done_status == STATUS_OK);

    // Fill level follows successful commands only
    always_ff @(posedge clk) begin
        if (__srst) begin
            fill <= '0;
        end else if (done && done_ok) begin
            case (done_command)
                COMMAND_SET:   fill <= fill + 1'b1;
                COMMAND_UNSET: fill <= fill - 1'b1;
                COMMAND_CLEAR: fill <= '0;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (__srst) begin
            insert_fail_cnt <= '0;
            delete_fail_cnt <= '0;
        end else if (done && !done_ok) begin
            if (done_command == COMMAND_SET)   insert_fail_cnt <= insert_fail_cnt + 1'b1;
            if (done_command == COMMAND_UNSET) delete_fail_cnt <= delete_fail_cnt + 1'b1;
        end
    end

    assign empty = (fill == '0);

    a_fill_max: assert property (@(posedge clk) disable iff (__srst) fill <= TOTAL_SLOTS)
        else $error("fill above table capacity");

endmodule : cuckoo_stats

// ==== hdl/cuckoo_htable.sv ====
module cuckoo_htable (
    input  logic                 clk,
    input  logic                 __srst,
    // Request port
    input  logic                 req,
    input  cuckoo_pkg::command_t command,
    input  cuckoo_pkg::key_t     key,
    input  cuckoo_pkg::value_t   set_value,
    output logic                 rdy,
    output logic                 ack,
    output cuckoo_pkg::status_t  status,
    output logic                 get_valid,
    output cuckoo_pkg::key_t     get_key,
    output cuckoo_pkg::value_t   get_value,
    // Statistics
    output cuckoo_pkg::fill_t    fill,
    output logic                 empty,
    output cuckoo_pkg::cnt_t     insert_fail_cnt,
    output cuckoo_pkg::cnt_t     delete_fail_cnt
);
    import cuckoo_pkg::*;

    command_t done_command;
    status_t  done_status;

    cuckoo_bank_if bank_if ();

    cuckoo_controller i_controller (
        .clk          ( clk ),
        .__srst       ( __srst ),
        .req          ( req ),
        .command      ( command ),
        .key          ( key ),
        .set_value    ( set_value ),
        .rdy          ( rdy ),
        .ack          ( ack ),
        .status       ( status ),
        .get_valid    ( get_valid ),
        .get_key      ( get_key ),
        .get_value    ( get_value ),
        .done_command ( done_command ),
        .done_status  ( done_status ),
        .bank         ( bank_if.controller )
    );

    cuckoo_bank_array i_bank_array (
        .clk    ( clk ),
        .__srst ( __srst ),
        .bank   ( bank_if.bank )
    );

    // Every ack to the requester is a completed command
    cuckoo_stats i_stats (
        .clk             ( clk ),
        .__srst          ( __srst ),
        .done            ( ack ),
        .done_command    ( done_command ),
        .done_status     ( done_status ),
        .fill            ( fill ),
        .empty           ( empty ),
        .insert_fail_cnt ( insert_fail_cnt ),
        .delete_fail_cnt ( delete_fail_cnt )
    );

endmodule : cuckoo_htable

// ==== bench/cuckoo_htable_tb.sv ====
module cuckoo_htable_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cuckoo_pkg::*;

    localparam int CLK_PERIOD        = 40;
    localparam int RESET_CYCLES      = 16;
    localparam int RAND_OPS          = 60;
    localparam int DIRECTED_COMMANDS = 23;
    localparam int NUM_COMMANDS      = DIRECTED_COMMANDS + RAND_OPS;

    logic     clk = 1'b0;
    logic     __srst;
    logic     req;
    command_t command;
    key_t     key;
    value_t   set_value;
    logic     rdy;
    logic     ack;
    status_t  status;
    logic     get_valid;
    key_t     get_key;
    value_t   get_value;
    fill_t    fill;
    logic     empty;
    cnt_t     insert_fail_cnt;
    cnt_t     delete_fail_cnt;

    // Reference model and the expected response of the command in flight
    value_t  ref_map [key_t];
    status_t exp_status = STATUS_OK;
    logic    exp_valid = 1'b0;
    key_t    exp_key = '0;
    value_t  exp_value = '0;
    fill_t   exp_fill = '0;
    cnt_t    exp_ins_fail = '0;
    cnt_t    exp_del_fail = '0;
    status_t last_status;

    int errors = 0;
    int err_mark = 0;
    int tests = 0;
    int failed_tests = 0;
    int seed = 32'h6c476dcf;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cuckoo_htable DUT (
        .clk             ( clk ),
        .__srst          ( __srst ),
        .req             ( req ),
        .command         ( command ),
        .key             ( key ),
        .set_value       ( set_value ),
        .rdy             ( rdy ),
        .ack             ( ack ),
        .status          ( status ),
        .get_valid       ( get_valid ),
        .get_key         ( get_key ),
        .get_value       ( get_value ),
        .fill            ( fill ),
        .empty           ( empty ),
        .insert_fail_cnt ( insert_fail_cnt ),
        .delete_fail_cnt ( delete_fail_cnt )
    );

    // ----------------------------------------
    // Response checks against the model
    // ----------------------------------------
    a_status: assert property (@(posedge clk) disable iff (__srst) ack |-> status == exp_status)
        else begin
            errors++;
            $display("FAILED %0t: status %0d, expected %0d", $time, $sampled(status), exp_status);
        end

    a_hit: assert property (@(posedge clk) disable iff (__srst) ack |-> get_valid == exp_valid)
        else begin
            errors++;
            $display("FAILED %0t: get_valid %0b, expected %0b", $time, $sampled(get_valid),
                     exp_valid);
        end

    // Key and value read as zero on a miss
    a_data: assert property (@(posedge clk) disable iff (__srst)
        ack |-> get_key == exp_key && get_value == exp_value)
        else begin
            errors++;
            $display("FAILED %0t: got key %h value %h, expected key %h value %h", $time,
                     $sampled(get_key), $sampled(get_value), exp_key, exp_value);
        end

    // Statistics settle one cycle after ack
    a_stats: assert property (@(posedge clk) disable iff (__srst)
        ack |=> fill == exp_fill && empty == (exp_fill == '0) &&
                insert_fail_cnt == exp_ins_fail && delete_fail_cnt == exp_del_fail)
        else begin
            errors++;
            $display("FAILED %0t: fill %0d ins_fail %0d del_fail %0d, expected %0d %0d %0d",
                     $time, fill, insert_fail_cnt, delete_fail_cnt,
                     exp_fill, exp_ins_fail, exp_del_fail);
        end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic check_true(input bit cond, input string msg);
        assert (cond) else begin
            errors++;
            $display("FAILED %0t: %s", $time, msg);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // expect_fail marks an insert whose displacement chain loops
    task automatic run_command(input command_t cmd, input key_t k, input value_t v,
                               input bit expect_fail = 1'b0);
        @(negedge clk);
        while (!rdy) @(negedge clk);
        exp_status = STATUS_OK;
        exp_valid  = 1'b0;
        exp_key    = '0;
        exp_value  = '0;
        case (cmd)
            COMMAND_CLEAR: ref_map.delete();
            COMMAND_GET: begin
                if (ref_map.exists(k)) begin
                    exp_valid = 1'b1;
                    exp_key   = k;
                    exp_value = ref_map[k];
                end
            end
            COMMAND_SET: begin
                if (ref_map.exists(k) || expect_fail) begin
                    exp_status = STATUS_ERROR;
                    exp_ins_fail++;
                end else begin
                    ref_map[k] = v;
                end
            end
            COMMAND_UNSET: begin
                if (ref_map.exists(k)) begin
                    ref_map.delete(k);
                end else begin
                    exp_status = STATUS_ERROR;
                    exp_del_fail++;
                end
            end
            COMMAND_REPLACE: begin
                if (ref_map.exists(k)) ref_map[k] = v;
                else                   exp_status = STATUS_ERROR;
            end
            default: ;
        endcase
        exp_fill  = fill_t'(ref_map.num());
        req       = 1'b1;
        command   = cmd;
        key       = k;
        set_value = v;
        @(negedge clk);
        req     = 1'b0;
        command = COMMAND_NOP;
        while (!ack) @(negedge clk);
        last_status = status;
        // Keep expectations stable through the statistics check
        repeat (2) @(negedge clk);
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [31:0] rnd;
        key_t        pool [8];
        __srst    = 1'b1;
        req       = 1'b0;
        command   = COMMAND_NOP;
        key       = '0;
        set_value = '0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_true(!rdy && !ack, "rdy or ack high during reset");
        end
        __srst = 1'b0;
        check_true(empty && fill == '0, "table not empty after reset");
        end_test("reset");

        run_command(COMMAND_SET, 16'h1A05, 16'hBEEF);
        run_command(COMMAND_GET, 16'h1A05, '0);
        run_command(COMMAND_GET, 16'h2C07, '0);
        end_test("set and get");

        run_command(COMMAND_SET, 16'h1A05, 16'h1234);
        run_command(COMMAND_REPLACE, 16'h1A05, 16'h4321);
        run_command(COMMAND_GET, 16'h1A05, '0);
        run_command(COMMAND_UNSET, 16'h3D06, '0);
        run_command(COMMAND_SET, 16'h3D06, 16'h0606);
        run_command(COMMAND_UNSET, 16'h3D06, '0);
        end_test("command errors");

        // Same bank 0 slot, different bank 1 slots
        run_command(COMMAND_SET, 16'h0012, 16'hA012);
        run_command(COMMAND_SET, 16'h0022, 16'hA022);
        run_command(COMMAND_GET, 16'h0012, '0);
        run_command(COMMAND_GET, 16'h0022, '0);
        // Three keys sharing one slot per bank
        run_command(COMMAND_SET, 16'h0033, 16'hB033);
        run_command(COMMAND_SET, 16'h0133, 16'hB133);
        run_command(COMMAND_SET, 16'h0233, 16'hB233, 1'b1);
        check_true(last_status == STATUS_ERROR, "looping insert did not report an error");
        run_command(COMMAND_GET, 16'h0033, '0);
        run_command(COMMAND_GET, 16'h0133, '0);
        run_command(COMMAND_GET, 16'h0233, '0);
        end_test("displacement");

        run_command(COMMAND_CLEAR, '0, '0);
        run_command(COMMAND_GET, 16'h1A05, '0);
        run_command(COMMAND_GET, 16'h0022, '0);
        run_command(COMMAND_GET, 16'h0133, '0);
        check_true(empty, "table not empty after clear");
        end_test("clear");

        // Distinct low nibbles keep every key in its own bank 0 slot
        for (int i = 0; i < 8; i++) begin
            rnd     = $random(seed);
            pool[i] = {rnd[15:4], 4'(i)};
        end
        for (int n = 0; n < RAND_OPS; n++) begin
            rnd = $random(seed);
            case (rnd[5:4])
                2'd0:    run_command(COMMAND_SET, pool[rnd[2:0]], rnd[31:16]);
                2'd1:    run_command(COMMAND_UNSET, pool[rnd[2:0]], '0);
                default: run_command(COMMAND_GET, pool[rnd[2:0]], '0);
            endcase
        end
        end_test("random sequence");

        $display("tests %0d, failed tests %0d, failed checks %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------
    initial begin
        #((RESET_CYCLES + NUM_COMMANDS * 100) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d commands' time", NUM_COMMANDS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : cuckoo_htable_tb

// ==== flist.f ====
+incdir+hdl
hdl/cuckoo_pkg.sv
hdl/cuckoo_bank_if.sv
hdl/cuckoo_controller.sv
hdl/cuckoo_bank_array.sv
hdl/cuckoo_stats.sv
hdl/cuckoo_htable.sv
bench/cuckoo_htable_tb.sv

// ==== Bender.yml ====
package:
  name: cuckoo_htable

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cuckoo_pkg.sv
      - hdl/cuckoo_bank_if.sv
      - hdl/cuckoo_controller.sv
      - hdl/cuckoo_bank_array.sv
      - hdl/cuckoo_stats.sv
      - hdl/cuckoo_htable.sv
  - target: test
    files:
      - bench/cuckoo_htable_tb.sv
